/* hw/rv_frontend_pkg.sv */
// Shared width, opcode and bundle types for the RISC-V fetch front end that other files reference by scoped name
package rv_frontend_pkg;

    // ====================
    // Architectural constants
    // ====================

    // Word width of the core
    localparam int XLEN = 32;

    // Opcodes the static predictor acts on
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ====================
    // Instruction word views
    // ====================

    // B-type layout with offset bits scattered around the register fields
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // J-type layout with a 20-bit offset in its own bit order
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // Same word seen either way; opcode sits in bits 6:0 in both
    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // ====================
    // Bundles between blocks
    // ====================

    // Decode slot handed to the back end
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic            pred_taken;
    } fetch_t;

    // One-cycle strobe carrying the corrected fetch target from the back end
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect_t;

    // Early redirect from the static predictor
    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } pred_t;

endpackage

/* hw/imm_decode.sv */
// Combinational B-type and J-type offset extraction for the decode slot; used by rv_frontend_top
`timescale 1ns/100ps

module imm_decode (
    input  rv_frontend_pkg::instr_u             instr_i,
    output logic [rv_frontend_pkg::XLEN-1:0]    imm_b_o,
    output logic [rv_frontend_pkg::XLEN-1:0]    imm_j_o
);

    // Field views of the same word
    rv_frontend_pkg::b_fmt_t b_view;
    rv_frontend_pkg::j_fmt_t j_view;

    // Sign bits of each offset
    logic b_sign;
    logic j_sign;

    assign b_view = instr_i.b_fmt;
    assign j_view = instr_i.j_fmt;

    // Both offsets keep their sign in instruction bit 31
    assign b_sign = b_view.imm12;
    assign j_sign = j_view.imm20;

    // ====================
    // B-type offset
    // ====================

    // 13-bit offset laid out as 12 | 11 | 10:5 | 4:1 | 0
    // Bit 11 lives down at instruction bit 7
    assign imm_b_o = {
        {(rv_frontend_pkg::XLEN-13){b_sign}},
        b_sign,
        b_view.imm11,
        b_view.imm10_5,
        b_view.imm4_1,
        1'b0
    };

    // ====================
    // J-type offset
    // ====================

    // 21-bit offset laid out as 20 | 19:12 | 11 | 10:1 | 0
    // Bits 19:12 stay in place and the rest is rotated up from 30:20
    assign imm_j_o = {
        {(rv_frontend_pkg::XLEN-21){j_sign}},
        j_sign,
        j_view.imm19_12,
        j_view.imm11,
        j_view.imm10_1,
        1'b0
    };

    // Both are always computed and the predictor picks by opcode
    // Halfword alignment is implied since bit 0 is never encoded

endmodule

/* hw/branch_predict.sv */
// Static predictor for the decode slot that takes JAL and backward branches; used by rv_frontend_top
`timescale 1ns/100ps

module branch_predict (
    input  logic [6:0]                          opcode_i,
    input  logic                                hazard_i,
    input  logic                                killed_i,
    input  logic                                jump_i,
    input  logic [rv_frontend_pkg::XLEN-1:0]    imm_b_i,
    input  logic [rv_frontend_pkg::XLEN-1:0]    imm_j_i,
    input  logic [rv_frontend_pkg::XLEN-1:0]    pc_i,
    input  logic                                predicted_r_i,
    output rv_frontend_pkg::pred_t              pred_o
);

    logic                             is_jal;
    logic                             is_branch;
    logic                             backward;
    logic                             slot_blocked;
    logic [rv_frontend_pkg::XLEN-1:0] offset;

    // ====================
    // Offset select
    // ====================

    always_comb begin
        is_jal    = 1'b0;
        is_branch = 1'b0;
        offset    = '0;
        case (opcode_i)
            rv_frontend_pkg::OPC_JAL: begin
                is_jal = 1'b1;
                offset = imm_j_i;
            end
            rv_frontend_pkg::OPC_BRANCH: begin
                is_branch = 1'b1;
                offset    = imm_b_i;
            end
            default: begin
                // Not a PC-relative control transfer
                offset = '0;
            end
        endcase
    end

    // Negative offset means a loop edge that is likely taken
    assign backward = offset[rv_frontend_pkg::XLEN-1];

    // No prediction on a wrong-path slot, behind one just made,
    // under a back-end redirect or while the slot is stalled
    assign slot_blocked = killed_i || predicted_r_i || jump_i || hazard_i;

    assign pred_o.taken  = (is_jal || (is_branch && backward)) && !slot_blocked;
    assign pred_o.target = pc_i + offset;

endmodule

/* hw/fetch_unit.sv */
// Program counter, next-address selection and decode slot state; instantiated by rv_frontend_top
`timescale 1ns/100ps

module fetch_unit #(
    parameter logic [rv_frontend_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                hazard_i,
    input  rv_frontend_pkg::redirect_t          redirect_i,
    input  rv_frontend_pkg::pred_t              pred_i,
    output logic [rv_frontend_pkg::XLEN-1:0]    imem_addr_o,
    input  logic [rv_frontend_pkg::XLEN-1:0]    imem_data_i,
    output logic [rv_frontend_pkg::XLEN-1:0]    slot_pc_o,
    output rv_frontend_pkg::instr_u             slot_instr_o,
    output logic                                slot_valid_o,
    output logic                                predicted_r_o,
    output logic                                killed_r_o
);

    // Address of the next word to fetch
    logic [rv_frontend_pkg::XLEN-1:0] pc_q;
    logic [rv_frontend_pkg::XLEN-1:0] pc_d;

    // Address whose word is in the decode slot this cycle
    logic [rv_frontend_pkg::XLEN-1:0] slot_pc_q;

    // Slot bookkeeping
    logic started_q;
    logic predicted_q;
    logic killed_q;
    logic slot_en;

    // ====================
    // Memory address
    // ====================

    // On a stall, refetch the held slot so its word is still on the bus
    // when the stall ends
    assign imem_addr_o = hazard_i ? slot_pc_q : pc_q;

    // ====================
    // Next PC
    // ====================

    // Priority order is back-end redirect, stall, prediction, sequential
    always_comb begin
        if (redirect_i.valid) begin
            pc_d = redirect_i.pc;
        end else if (hazard_i) begin
            pc_d = pc_q;
        end else if (pred_i.taken) begin
            pc_d = pred_i.target;
        end else begin
            pc_d = pc_q + rv_frontend_pkg::XLEN'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // ====================
    // Decode slot
    // ====================

    // A redirect flushes the slot even when the back end is stalled
    assign slot_en = redirect_i.valid || !hazard_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_pc_q   <= RESET_PC;
            started_q   <= 1'b0;
            predicted_q <= 1'b0;
            killed_q    <= 1'b0;
        end else if (slot_en) begin
            // Word issued now lands in the slot next cycle
            slot_pc_q   <= imem_addr_o;
            started_q   <= 1'b1;
            // Sequential word behind a redirect or a taken prediction is wrong-path
            killed_q    <= redirect_i.valid;
            predicted_q <= pred_i.taken;
        end
    end

    // Memory output is meaningless until the first address was issued;
    // an all-zero word decodes as neither jump nor branch
    assign slot_instr_o  = started_q ? imem_data_i : '0;
    assign slot_pc_o     = slot_pc_q;

    // Slot is live once filled, not squashed, and not being flushed now
    assign slot_valid_o  = started_q && !killed_q && !predicted_q && !redirect_i.valid;

    assign predicted_r_o = predicted_q;
    assign killed_r_o    = killed_q;

endmodule

/* hw/rv_frontend_top.sv */
// Instruction front end top level that wires fetch, immediate decode and static prediction together
`timescale 1ns/100ps

module rv_frontend_top #(
    parameter logic [rv_frontend_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    output logic [rv_frontend_pkg::XLEN-1:0]    imem_addr_o,
    input  logic [rv_frontend_pkg::XLEN-1:0]    imem_data_i,
    input  logic                                hazard_i,
    input  rv_frontend_pkg::redirect_t          redirect_i,
    output rv_frontend_pkg::fetch_t             fetch_o
);

    // Decode slot
    logic [rv_frontend_pkg::XLEN-1:0] slot_pc;
    rv_frontend_pkg::instr_u          slot_instr;
    logic                             slot_valid;
    logic                             predicted_r;
    logic                             killed_r;

    // Offsets and prediction
    logic [rv_frontend_pkg::XLEN-1:0] imm_b;
    logic [rv_frontend_pkg::XLEN-1:0] imm_j;
    rv_frontend_pkg::pred_t           pred;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) i_fetch_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .hazard_i      (hazard_i),
        .redirect_i    (redirect_i),
        .pred_i        (pred),
        .imem_addr_o   (imem_addr_o),
        .imem_data_i   (imem_data_i),
        .slot_pc_o     (slot_pc),
        .slot_instr_o  (slot_instr),
        .slot_valid_o  (slot_valid),
        .predicted_r_o (predicted_r),
        .killed_r_o    (killed_r)
    );

    imm_decode i_imm_decode (
        .instr_i (slot_instr),
        .imm_b_o (imm_b),
        .imm_j_o (imm_j)
    );

    // Redirect strobe doubles as the jump input of the predictor
    branch_predict i_branch_predict (
        .opcode_i      (slot_instr.b_fmt.opcode),
        .hazard_i      (hazard_i),
        .killed_i      (killed_r),
        .jump_i        (redirect_i.valid),
        .imm_b_i       (imm_b),
        .imm_j_i       (imm_j),
        .pc_i          (slot_pc),
        .predicted_r_i (predicted_r),
        .pred_o        (pred)
    );

    // Slot as the back end sees it
    assign fetch_o = '{
        valid:      slot_valid,
        pc:         slot_pc,
        instr:      slot_instr,
        pred_taken: pred.taken
    };

endmodule

/* tb/rv_frontend_properties.sv */
// Concurrent checks on prediction, redirect and stall behavior, bound into rv_frontend_top by the testbench
`timescale 1ns/100ps

module rv_frontend_properties #(
    parameter logic [rv_frontend_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic [rv_frontend_pkg::XLEN-1:0]    imem_addr_i,
    input  logic                                hazard_i,
    input  rv_frontend_pkg::redirect_t          redirect_i,
    input  rv_frontend_pkg::fetch_t             fetch_i
);

    // Failures seen so far that the testbench reads for its report
    int unsigned fail_count = 0;

    // Slot opcode and the JAL target rebuilt straight from the ISA encoding
    logic [6:0]                       slot_opcode;
    logic [rv_frontend_pkg::XLEN-1:0] jal_target;
    logic                             slot_live;

    // J-type offset laid out as sign | 19:12 | 11 | 10:1 | 0
    function automatic logic [31:0] jal_offset(input logic [31:0] word);
        return {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    endfunction

    assign slot_opcode = fetch_i.instr[6:0];
    assign jal_target  = fetch_i.pc + jal_offset(fetch_i.instr);

    // Valid slot that the back end takes this cycle
    assign slot_live   = fetch_i.valid && !hazard_i;

    // ====================
    // Reset
    // ====================

    // First cycle out of reset fetches RESET_PC with an empty slot
    a_reset_start: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (imem_addr_i == RESET_PC) && !fetch_i.valid)
        else begin
            fail_count++;
            $error("fetch did not start at RESET_PC with an empty slot");
        end

    // ====================
    // Prediction
    // ====================

    // JAL is always taken and fetch jumps to pc plus J offset
    a_jal_taken: assert property (@(posedge clk) disable iff (!rst_n_i)
        slot_live && (slot_opcode == rv_frontend_pkg::OPC_JAL) |-> fetch_i.pred_taken)
        else begin
            fail_count++;
            $error("JAL in a live slot was not predicted taken");
        end

    a_jal_target: assert property (@(posedge clk) disable iff (!rst_n_i)
        slot_live && (slot_opcode == rv_frontend_pkg::OPC_JAL)
            |=> hazard_i || (imem_addr_i == $past(jal_target)))
        else begin
            fail_count++;
            $error("fetch address after JAL is not the jump target");
        end

    // Branch taken exactly when its offset is negative
    a_branch_dir: assert property (@(posedge clk) disable iff (!rst_n_i)
        slot_live && (slot_opcode == rv_frontend_pkg::OPC_BRANCH)
            |-> fetch_i.pred_taken == fetch_i.instr[31])
        else begin
            fail_count++;
            $error("branch prediction does not follow the offset sign");
        end

    // Forward branch falls through to the next word
    a_branch_seq: assert property (@(posedge clk) disable iff (!rst_n_i)
        slot_live && (slot_opcode == rv_frontend_pkg::OPC_BRANCH) && !fetch_i.instr[31]
            |=> hazard_i || (imem_addr_i == $past(imem_addr_i) + 32'd4))
        else begin
            fail_count++;
            $error("fetch did not continue sequentially after a forward branch");
        end

    // ====================
    // Squash and redirect
    // ====================

    // Wrong-path slot behind a prediction or a redirect
    a_squash: assert property (@(posedge clk) disable iff (!rst_n_i)
        fetch_i.pred_taken || redirect_i.valid |=> !fetch_i.valid && !fetch_i.pred_taken)
        else begin
            fail_count++;
            $error("slot after a prediction or redirect was not squashed");
        end

    // The strobe cycle itself is dead and makes no prediction
    a_redirect_now: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_i.valid |-> !fetch_i.valid && !fetch_i.pred_taken)
        else begin
            fail_count++;
            $error("slot stayed live during a redirect strobe");
        end

    a_redirect_addr: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_i.valid |=> hazard_i || (imem_addr_i == $past(redirect_i.pc)))
        else begin
            fail_count++;
            $error("fetch address after a redirect is not the redirect target");
        end

    // ====================
    // Stall
    // ====================

    a_stall_no_pred: assert property (@(posedge clk) disable iff (!rst_n_i)
        hazard_i |-> !fetch_i.pred_taken)
        else begin
            fail_count++;
            $error("prediction made while the back end was stalled");
        end

    // Held slot presented unchanged across consecutive stall cycles
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        hazard_i && $past(hazard_i) && !redirect_i.valid && !$past(redirect_i.valid)
            |-> fetch_i == $past(fetch_i))
        else begin
            fail_count++;
            $error("decode slot changed during a stall");
        end

endmodule

/* tb/tb_rv_frontend.sv */
// Testbench for rv_frontend_top that runs a random program from a synchronous memory model in four phases
`timescale 1ns/100ps

module tb_rv_frontend;

    // ====================
    // Run lengths
    // ====================

    localparam int unsigned SEED           = 28393;
    localparam int unsigned RESET_CYCLES   = 5;
    localparam int unsigned PHASE_CYCLES   = 400;
    localparam int unsigned NUM_PHASES     = 4;
    localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + NUM_PHASES * PHASE_CYCLES + 50;

    logic                       clk = 1'b0;
    logic                       rst_n = 1'b0;
    logic [31:0]                imem_addr;
    logic [31:0]                imem_data = '0;
    logic                       hazard = 1'b0;
    rv_frontend_pkg::redirect_t redirect = '0;
    rv_frontend_pkg::fetch_t    fetch;

    // Program image of 256 words that wraps on the address
    logic [31:0] mem [256];

    int unsigned tb_errors     = 0;
    int unsigned words_checked = 0;
    int unsigned cycle_count   = 0;
    int unsigned phases_passed = 0;
    int unsigned phases_failed = 0;

    always #20 clk = ~clk;

    rv_frontend_top i_dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .hazard_i    (hazard),
        .redirect_i  (redirect),
        .fetch_o     (fetch)
    );

    bind rv_frontend_top rv_frontend_properties #(
        .RESET_PC (RESET_PC)
    ) i_properties (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .imem_addr_i (imem_addr_o),
        .hazard_i    (hazard_i),
        .redirect_i  (redirect_i),
        .fetch_i     (fetch_o)
    );

    // ====================
    // Program generation
    // ====================

    // JAL fields imm 20 | 10:1 | 11 | 19:12 | rd | opcode
    function automatic logic [31:0] encode_jal(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_frontend_pkg::OPC_JAL};
    endfunction

    // Branch fields imm 12 | 10:5 | rs2 | rs1 | funct3 | 4:1 | 11 | opcode
    function automatic logic [31:0] encode_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                                  input logic [4:0] rs2, input logic [31:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_frontend_pkg::OPC_BRANCH};
    endfunction

    // One JAL in four, one branch in four, the rest ALU immediates
    function automatic logic [31:0] random_program_word();
        int unsigned kind;
        int          off_words;
        logic [31:0] off;
        logic [31:0] raw;
        logic [2:0]  f3;
        kind      = $urandom_range(3);
        raw       = $urandom();
        off_words = int'($urandom_range(127)) - 64;
        // Zero offset would spin on one word forever
        if (off_words == 0) begin
            off_words = 1;
        end
        off = off_words * 4;
        f3  = raw[14:12];
        // funct3 2 and 3 are not branches
        if (f3 == 3'd2 || f3 == 3'd3) begin
            f3 = 3'd0;
        end
        case (kind)
            0: return encode_jal(raw[11:7], off);
            1: return encode_branch(f3, raw[19:15], raw[24:20], off);
            default: return {raw[31:7], 7'b0010011};
        endcase
    endfunction

    // ====================
    // Memory model
    // ====================

    // Word for the address of cycle n shows up in cycle n+1
    always @(posedge clk) begin
        imem_data <= mem[imem_addr[9:2]];
    end

    // Every live slot must carry the word stored at its pc
    always @(negedge clk) begin
        if (rst_n && fetch.valid) begin
            words_checked <= words_checked + 1;
            if (fetch.instr !== mem[fetch.pc[9:2]]) begin
                tb_errors <= tb_errors + 1;
                $display("ERROR %0t: fetch_o.instr at pc %h expected %h got %h",
                         $time, fetch.pc, mem[fetch.pc[9:2]], fetch.instr);
            end
        end
    end

    // ====================
    // Timeout
    // ====================

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic int unsigned error_total();
        return tb_errors + i_dut.i_properties.fail_count;
    endfunction

    // One phase of random stall and redirect traffic with per-cycle percentages
    task automatic run_phase(input int num, input string name,
                             input int unsigned hazard_pct, input int unsigned redirect_pct);
        int unsigned errors_before;
        int unsigned errors_seen;
        logic [7:0]  word_idx;
        errors_before = error_total();
        repeat (PHASE_CYCLES) begin
            @(posedge clk);
            word_idx = 8'($urandom_range(255));
            hazard       <= ($urandom_range(99) < hazard_pct);
            redirect.valid <= ($urandom_range(99) < redirect_pct);
            redirect.pc  <= {22'd0, word_idx, 2'b00};
        end
        // Back to quiet inputs so the next phase starts clean
        @(posedge clk);
        hazard   <= 1'b0;
        redirect <= '0;
        errors_seen = error_total() - errors_before;
        if (errors_seen == 0) begin
            phases_passed++;
        end else begin
            phases_failed++;
        end
        $display("Phase %0d %s: %0d errors, %0d slot words checked so far",
                 num, name, errors_seen, words_checked);
    endtask

    // ====================
    // Stimulus
    // ====================

    initial begin
        rst_n    = 1'b0;
        hazard   = 1'b0;
        redirect = '0;
        void'($urandom(SEED));
        for (int i = 0; i < 256; i++) begin
            mem[i] = random_program_word();
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        run_phase(1, "free run", 0, 0);
        run_phase(2, "random hazards", 20, 0);
        run_phase(3, "random redirects", 0, 10);
        run_phase(4, "hazards and redirects", 20, 10);

        // Let the last implications settle
        repeat (3) @(posedge clk);
        $display("Summary: %0d phases passed, %0d phases failed, %0d errors",
                 phases_passed, phases_failed, error_total());
        if (error_total() == 0 && phases_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
hw/rv_frontend_pkg.sv
hw/imm_decode.sv
hw/branch_predict.sv
hw/fetch_unit.sv
hw/rv_frontend_top.sv
tb/rv_frontend_properties.sv
tb/tb_rv_frontend.sv

/* run_sim.sh */
#!/bin/sh
# Build the front end and its testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -f sim.f --top-module tb_rv_frontend \
    -o sim_rv_frontend > "$LOG" 2>&1 &&
    ./obj_dir/sim_rv_frontend +verilator+error+limit+1000 >> "$LOG" 2>&1 ||
    echo "Build or simulation returned an error status" >> "$LOG"
cat "$LOG"
grep -q "^\*\*\* TEST PASSED \*\*\*$" "$LOG" && echo "Simulation passed" && exit 0 ||
    { echo "Simulation failed"; exit 1; }
